/* flist.f */
hw/mem_pkg.sv
hw/mem_fixed_priority_arbiter.sv
hw/mem_switch.sv
hw/mem_model.sv
hw/mem_subsys_top.sv
test/mem_subsys_assert.sv
test/mem_subsys_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module mem_subsys_tb \
    -Mdir "$BUILD_DIR" -o mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/mem_subsys_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides pass or fail
if grep -q "^All tests passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* test/mem_subsys_tb.sv */
/*
 * Memory subsystem testbench
 * Plays fetch and two MSHR requesters against a reference memory
 */

`timescale 1ns/1ps

module mem_subsys_tb;

    import mem_pkg::*;

    logic                      clk_i;
    logic                      reset_i;
    mem_in_t [MEM_REQ_NUM-1:0] req;
    logic [MEM_REQ_NUM-1:0]    grant;
    mem_out_t                  mem_out;

    // Reference memory, loads in flight indexed by tag
    mem_data_t ref_mem [MEM_DEPTH];
    mem_data_t pend_data [16];
    int        pend_tick [16];
    logic      pend_valid [16];
    int        pend_cnt;
    int        max_pend;
    int        returns;
    mem_tag_t  exp_tag;

    // Per requester command lists
    mem_in_t   cmd_list [MEM_REQ_NUM][32];
    int        cmd_len [MEM_REQ_NUM];
    int        cmd_pos [MEM_REQ_NUM];
    int        drive_tick [MEM_REQ_NUM];

    // Accept log, cleared by reset
    int        log_idx [64];
    int        log_wait [64];
    mem_tag_t  log_tag [64];
    int        acc_n;
    logic      acc_valid;
    int        acc_idx;
    int        tick_cnt;
    int        errors;
    int        tests_run;
    int        tests_failed;

    mem_subsys_top i_mem_subsys_top (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (req),
        .grant_o   (grant),
        .mem_out_o (mem_out)
    );

    always #2 clk_i = ~clk_i;

    // ========================================================
    // Checking helpers
    // ========================================================
    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // Sampled on the falling edge, before new inputs go out
    task automatic observe();
        tick_cnt++;
        acc_valid = 1'b0;
        // Return first, its tag may be handed out again below
        if (mem_out.tag != '0) begin
            if (!pend_valid[mem_out.tag]) begin
                $display("Load data returned with unknown tag %0d at %0t", mem_out.tag, $time);
                errors++;
            end else begin
                compare(64'(mem_out.data), 64'(pend_data[mem_out.tag]), "load data");
                compare(64'(tick_cnt - pend_tick[mem_out.tag]), 64'(MEM_LATENCY), "latency");
                pend_valid[mem_out.tag] = 1'b0;
                pend_cnt--;
                returns++;
            end
        end
        if (mem_out.response != '0 && grant != '0) begin
            acc_valid = 1'b1;
            for (int r = 0; r < MEM_REQ_NUM; r++) begin
                if (grant[r]) acc_idx = r;
            end
            compare(64'(mem_out.response), 64'(exp_tag), "response tag");
            // Tags run 1 to 15, then back to 1
            exp_tag = (exp_tag == 4'd15) ? 4'd1 : exp_tag + 4'd1;
            if (req[acc_idx].command == BUS_STORE) begin
                ref_mem[req[acc_idx].addr] = req[acc_idx].data;
            end else begin
                pend_valid[mem_out.response] = 1'b1;
                pend_data[mem_out.response] = ref_mem[req[acc_idx].addr];
                pend_tick[mem_out.response] = tick_cnt;
                pend_cnt++;
                max_pend = (pend_cnt > max_pend) ? pend_cnt : max_pend;
            end
            log_idx[acc_n] = acc_idx;
            log_wait[acc_n] = tick_cnt - drive_tick[acc_idx];
            log_tag[acc_n] = mem_out.response;
            acc_n++;
        end
    endtask

    task automatic tick();
        @(negedge clk_i);
        observe();
    endtask

    // ========================================================
    // Stimulus helpers
    // ========================================================
    task automatic do_reset();
        reset_i = 1'b1;
        req = '0;
        for (int i = 0; i < MEM_DEPTH; i++) ref_mem[i] = '0;
        for (int t = 0; t < 16; t++) pend_valid[t] = 1'b0;
        for (int r = 0; r < MEM_REQ_NUM; r++) cmd_len[r] = 0;
        pend_cnt = 0;
        max_pend = 0;
        returns = 0;
        acc_n = 0;
        exp_tag = 4'd1;
        repeat (4) @(negedge clk_i);
        reset_i = 1'b0;
    endtask

    task automatic add_cmd(input int r, input bus_command_e c, input mem_addr_t a,
                           input mem_data_t d);
        cmd_list[r][cmd_len[r]] = '{command: c, addr: a, data: d};
        cmd_len[r]++;
    endtask

    task automatic present_next(input int r);
        if (cmd_pos[r] < cmd_len[r]) begin
            req[r] = cmd_list[r][cmd_pos[r]];
            cmd_pos[r]++;
        end else begin
            req[r] = '0;
        end
        drive_tick[r] = tick_cnt;
    endtask

    // Runs every command list to the end, then drains load returns
    task automatic serve();
        logic retire [MEM_REQ_NUM];
        logic busy;
        int   waited;
        busy = 1'b1;
        waited = 0;
        for (int r = 0; r < MEM_REQ_NUM; r++) begin
            cmd_pos[r] = 0;
            retire[r] = 1'b0;
            present_next(r);
        end
        while (busy && waited < 400) begin
            tick();
            waited++;
            busy = 1'b0;
            for (int r = 0; r < MEM_REQ_NUM; r++) begin
                // Accepted one edge ago, swap in the next command
                if (retire[r]) begin
                    retire[r] = 1'b0;
                    present_next(r);
                end
                if (acc_valid && acc_idx == r) retire[r] = 1'b1;
                if (req[r].command != BUS_NONE) busy = 1'b1;
            end
        end
        if (busy) begin
            $display("Timeout: requesters still waiting for a grant at %0t", $time);
            errors++;
        end
        waited = 0;
        while (pend_cnt != 0 && waited < 20) begin
            tick();
            waited++;
        end
        if (pend_cnt != 0) begin
            $display("Timeout: %0d loads never returned data", pend_cnt);
            errors++;
        end
        for (int r = 0; r < MEM_REQ_NUM; r++) cmd_len[r] = 0;
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, errors - err_start);
        end
    endtask

    // ========================================================
    // Directed tests
    // ========================================================
    task automatic test_reset_state();
        int err_start;
        err_start = errors;
        do_reset();
        tick();
        compare(64'(grant), 64'(0), "grant after reset");
        compare(64'(mem_out.response), 64'(0), "response after reset");
        compare(64'(mem_out.tag), 64'(0), "tag after reset");
        add_cmd(2, BUS_LOAD, 8'h10, '0);
        serve();
        compare(64'(acc_n), 64'(1), "accept count");
        compare(64'(log_tag[0]), 64'(1), "first tag");
        finish_test("reset_state", err_start);
    endtask

    task automatic test_single();
        int err_start;
        err_start = errors;
        do_reset();
        add_cmd(1, BUS_STORE, 8'h2a, 64'hdead_beef_0123_4567);
        add_cmd(1, BUS_LOAD, 8'h2a, '0);
        serve();
        compare(64'(acc_n), 64'(2), "accept count");
        // Lone request, granted one cycle after it shows up
        compare(64'(log_wait[0]), 64'(1), "store grant delay");
        compare(64'(log_wait[1]), 64'(1), "load grant delay");
        compare(64'(returns), 64'(1), "load returns");
        finish_test("single_requester", err_start);
    endtask

    task automatic test_priority();
        int err_start;
        err_start = errors;
        do_reset();
        add_cmd(0, BUS_LOAD, 8'h01, '0);
        add_cmd(1, BUS_STORE, 8'h01, 64'h1111_2222_3333_4444);
        add_cmd(2, BUS_LOAD, 8'h01, '0);
        serve();
        compare(64'(acc_n), 64'(3), "accept count");
        // Losers keep waiting, one accept every two cycles
        for (int i = 0; i < 3; i++) begin
            compare(64'(log_idx[i]), 64'(i), "accept order");
            compare(64'(log_wait[i]), 64'(1 + 2 * i), "cycles pending");
        end
        finish_test("fixed_priority", err_start);
    endtask

    task automatic test_tags();
        int err_start;
        err_start = errors;
        do_reset();
        for (int i = 0; i < 4; i++) add_cmd(0, BUS_STORE, mem_addr_t'(i), {$urandom(), $urandom()});
        serve();
        for (int i = 0; i < 20; i++) add_cmd(1, BUS_LOAD, mem_addr_t'(i % 4), '0);
        serve();
        compare(64'(acc_n), 64'(24), "accept count");
        for (int n = 0; n < acc_n; n++) begin
            compare(64'(log_tag[n]), 64'((n % 15) + 1), "tag sequence");
        end
        compare(64'(max_pend >= 2), 64'(1), "loads in flight");
        compare(64'(returns), 64'(20), "load returns");
        finish_test("tags", err_start);
    endtask

    task automatic test_random();
        int        err_start;
        int        loads;
        mem_addr_t a;
        err_start = errors;
        loads = 0;
        do_reset();
        for (int r = 0; r < MEM_REQ_NUM; r++) begin
            for (int i = 0; i < 12; i++) begin
                // Four addresses keep loads and stores colliding
                a = mem_addr_t'($urandom_range(3, 0));
                if ($urandom_range(1, 0) == 1) begin
                    add_cmd(r, BUS_LOAD, a, '0);
                    loads++;
                end else begin
                    add_cmd(r, BUS_STORE, a, {$urandom(), $urandom()});
                end
            end
        end
        serve();
        compare(64'(acc_n), 64'(36), "accept count");
        compare(64'(returns), 64'(loads), "load returns");
        finish_test("random_traffic", err_start);
    endtask

    initial begin
        clk_i = 1'b0;
        reset_i = 1'b1;
        req = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        tick_cnt = 0;
        void'($urandom(32'had23_6504));
        test_reset_state();
        test_single();
        test_priority();
        test_tags();
        test_random();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* test/mem_subsys_assert.sv */
/*
 * Memory subsystem assertions
 * Grant and acceptance rules on the top level ports
 */

`timescale 1ns/1ps

module mem_subsys_assert (
    input logic                                        clk_i,
    input logic                                        reset_i,
    input mem_pkg::mem_in_t [mem_pkg::MEM_REQ_NUM-1:0] req_i,
    input logic [mem_pkg::MEM_REQ_NUM-1:0]             grant_i,
    input mem_pkg::mem_out_t                           mem_out_i
);

    import mem_pkg::*;

    logic accept;

    // Granted and tagged in the same cycle
    assign accept = (grant_i != '0) && (mem_out_i.response != '0);

    grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(grant_i))
        else $error("grant is not one-hot or zero");

    // Only a live command may hold the port
    for (genvar r = 0; r < MEM_REQ_NUM; r++) begin : g_granted_cmd
        granted_live: assert property (@(posedge clk_i) disable iff (reset_i)
            grant_i[r] |-> req_i[r].command != BUS_NONE)
            else $error("requester %0d granted without a command", r);
    end

    idle_no_response: assert property (@(posedge clk_i) disable iff (reset_i)
        grant_i == '0 |-> mem_out_i.response == '0)
        else $error("response without a grant");

    // Arbiter idles one cycle after every acknowledge
    accept_spacing: assert property (@(posedge clk_i) disable iff (reset_i) accept |=> !accept)
        else $error("accepts in consecutive cycles");

endmodule

bind mem_subsys_top mem_subsys_assert i_mem_subsys_assert (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .grant_i   (grant_o),
    .mem_out_i (mem_out_o)
);

/* hw/mem_subsys_top.sv */
/*
 * Memory subsystem top level
 * Switch in front of the memory model, one shared port
 */

`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                                      clk_i,
    input  logic                                      reset_i,
    input  mem_pkg::mem_in_t [mem_pkg::MEM_REQ_NUM-1:0] req_i,
    output logic [mem_pkg::MEM_REQ_NUM-1:0]           grant_o,
    output mem_pkg::mem_out_t                         mem_out_o
);

    import mem_pkg::*;

    // Routed command and memory return
    mem_in_t  switch2mem;
    mem_out_t mem2switch;

    mem_switch i_mem_switch (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req2mem_i      (req_i),
        .mem2switch_i   (mem2switch),
        .memory_grant_o (grant_o),
        .switch2mem_o   (switch2mem)
    );

    mem_model i_mem_model (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .mem_i   (switch2mem),
        .mem_o   (mem2switch)
    );

    // Broadcast to all requesters
    assign mem_out_o = mem2switch;

endmodule

/* hw/mem_model.sv */
/*
 * Tagged memory model
 * Accepts every command and returns load data after a fixed latency
 */

`timescale 1ns/1ps

module mem_model (
    input  logic              clk_i,
    input  logic              reset_i,
    input  mem_pkg::mem_in_t  mem_i,
    output mem_pkg::mem_out_t mem_o
);

    import mem_pkg::*;

    mem_data_t mem_array [MEM_DEPTH];

    // Next tag to hand out
    mem_tag_t  tag_cnt_q;
    logic      accept;
    logic      load_accept;
    mem_data_t rd_data;

    // Stage 0 of the load return pipe is written at acceptance
    mem_tag_t  tag_pipe_q  [MEM_LATENCY];
    mem_data_t data_pipe_q [MEM_LATENCY];

    // ========================================================
    // Acceptance
    // ========================================================
    assign accept      = (mem_i.command != BUS_NONE);
    assign load_accept = (mem_i.command == BUS_LOAD);
    assign rd_data     = mem_array[mem_i.addr];

    // Tag goes back in the same cycle
    assign mem_o.response = accept ? tag_cnt_q : '0;

    // Wraps from 15 back to 1 and never hands out 0
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tag_cnt_q <= mem_tag_t'(1);
        end else if (accept) begin
            if (tag_cnt_q == '1) begin
                tag_cnt_q <= mem_tag_t'(1);
            end else begin
                tag_cnt_q <= tag_cnt_q + mem_tag_t'(1);
            end
        end
    end

    // ========================================================
    // Storage
    // ========================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Contents come up as zero
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem_array[i] <= '0;
            end
        end else if (mem_i.command == BUS_STORE) begin
            mem_array[mem_i.addr] <= mem_i.data;
        end
    end

    // ========================================================
    // Load return pipeline
    // ========================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                tag_pipe_q[i] <= '0;
            end
        end else begin
            // Stores get a tag but never enter the pipe
            tag_pipe_q[0] <= load_accept ? tag_cnt_q : '0;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                tag_pipe_q[i] <= tag_pipe_q[i-1];
            end
        end
    end

    // Data travels alongside its tag
    always_ff @(posedge clk_i) begin
        data_pipe_q[0] <= rd_data;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_pipe_q[i] <= data_pipe_q[i-1];
        end
    end

    // Last stage lands MEM_LATENCY cycles after acceptance
    assign mem_o.tag  = tag_pipe_q[MEM_LATENCY-1];
    assign mem_o.data = data_pipe_q[MEM_LATENCY-1];

endmodule

/* hw/mem_switch.sv */
/*
 * Memory request switch
 * Routes the arbitrated requester onto the single memory port
 */

`timescale 1ns/1ps

module mem_switch (
    input  logic                                      clk_i,
    input  logic                                      reset_i,
    input  mem_pkg::mem_in_t [mem_pkg::MEM_REQ_NUM-1:0] req2mem_i,
    input  mem_pkg::mem_out_t                         mem2switch_i,
    output logic [mem_pkg::MEM_REQ_NUM-1:0]           memory_grant_o,
    output mem_pkg::mem_in_t                          switch2mem_o
);

    import mem_pkg::*;

    logic [MEM_REQ_NUM-1:0] arbiter_req;
    logic                   arbiter_ack;
    mem_req_idx_t           grant_idx;
    logic                   grant_valid;

    mem_fixed_priority_arbiter #(
        .REQ_NUM (MEM_REQ_NUM)
    ) i_mem_fixed_priority_arbiter (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (arbiter_req),
        .ack_i   (arbiter_ack),
        .grant_o (grant_idx),
        .valid_o (grant_valid)
    );

    // ========================================================
    // Request flags, acknowledge and routing
    // ========================================================
    always_comb begin
        // Every requester with a live command
        for (int i = 0; i < MEM_REQ_NUM; i++) begin
            arbiter_req[i] = (req2mem_i[i].command != BUS_NONE);
        end

        // Accepted when memory hands back a tag
        arbiter_ack = grant_valid && (mem2switch_i.response != '0);

        // Idle port by default
        switch2mem_o         = '0;
        switch2mem_o.command = BUS_NONE;
        memory_grant_o       = '0;
        if (grant_valid) begin
            switch2mem_o   = req2mem_i[grant_idx];
            memory_grant_o = {{(MEM_REQ_NUM-1){1'b0}}, 1'b1} << grant_idx;
        end
    end

endmodule

/* hw/mem_fixed_priority_arbiter.sv */
/*
 * Fixed priority arbiter for the memory port
 * Registers the lowest active index, holds it until acknowledged
 */

`timescale 1ns/1ps

module mem_fixed_priority_arbiter #(
    parameter int REQ_NUM = mem_pkg::MEM_REQ_NUM
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic [REQ_NUM-1:0]   req_i,
    input  logic                 ack_i,
    output mem_pkg::mem_req_idx_t grant_o,
    output logic                 valid_o
);

    import mem_pkg::*;

    typedef enum logic {
        ARB_IDLE,
        ARB_GRANT
    } arb_state_e;

    arb_state_e   state_q;
    mem_req_idx_t winner;
    mem_req_idx_t grant_q;

    // ========================================================
    // Priority pick
    // ========================================================
    always_comb begin
        winner = '0;
        // Scan downward so the lowest index wins
        for (int i = REQ_NUM - 1; i >= 0; i--) begin
            if (req_i[i]) begin
                winner = mem_req_idx_t'(i);
            end
        end
    end

    // ========================================================
    // Grant register
    // ========================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ARB_IDLE;
            grant_q <= '0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    // Pick only when someone is asking
                    if (|req_i) begin
                        grant_q <= winner;
                        state_q <= ARB_GRANT;
                    end
                end
                ARB_GRANT: begin
                    // One idle cycle follows, winner retires its command
                    if (ack_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    assign grant_o = grant_q;
    assign valid_o = (state_q == ARB_GRANT);

endmodule

/* hw/mem_pkg.sv */
/*
 * Memory subsystem package
 * Command encoding, width types, request and response structs
 */

package mem_pkg;

    // ========================================================
    // Sizing
    // ========================================================
    // Fetch on 0, MSHR entries on 1 and 2
    localparam int MEM_REQ_NUM   = 3;
    localparam int MEM_REQ_IDX_W = 2;
    // Acceptance to load data return, in cycles
    localparam int MEM_LATENCY   = 4;
    localparam int MEM_ADDR_W    = 8;
    localparam int MEM_DATA_W    = 64;
    localparam int MEM_TAG_W     = 4;
    localparam int MEM_DEPTH     = 1 << MEM_ADDR_W;

    // ========================================================
    // Types
    // ========================================================
    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_command_e;

    typedef logic [MEM_ADDR_W-1:0]    mem_addr_t;
    typedef logic [MEM_DATA_W-1:0]    mem_data_t;
    // Tag 0 is reserved for no response
    typedef logic [MEM_TAG_W-1:0]     mem_tag_t;
    typedef logic [MEM_REQ_IDX_W-1:0] mem_req_idx_t;

    // Requester command, also what goes to memory
    typedef struct packed {
        bus_command_e command;
        mem_addr_t    addr;
        mem_data_t    data;
    } mem_in_t;

    // Memory return, broadcast to every requester
    typedef struct packed {
        mem_tag_t  response;   // tag given to this cycle's command
        mem_tag_t  tag;        // tag of the load completing now
        mem_data_t data;
    } mem_out_t;

endpackage
